//--- source/rvseed_pkg.sv
package rvseed_pkg;

    // datapath widths
    localparam int xlen           = 64;
    localparam int inst_width     = 32;
    localparam int reg_addr_width = 5;

    localparam logic [xlen-1:0]       reset_pc    = 64'h0000_0000_8000_0000;
    localparam logic [inst_width-1:0] inst_ebreak = 32'h0010_0073;

    // accepted funct fields
    localparam logic [2:0] funct3_add  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;
    localparam logic [2:0] funct3_jalr = 3'b000;
    localparam logic [6:0] funct7_sub  = 7'b0100000;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_r_type = 7'b0110011,  // add, sub
        op_i_alu  = 7'b0010011,  // addi
        op_branch = 7'b1100011,  // bne
        op_store  = 7'b0100011,  // not implemented
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_system = 7'b1110011   // ebreak only
    } opcode_e;

    typedef enum logic [1:0] {
        alu_and = 2'd0,
        alu_add = 2'd1,
        alu_sub = 2'd2
    } alu_op_e;

    // operand pair seen by the alu
    typedef enum logic [1:0] {
        src_reg     = 2'd0,  // rs1, rs2
        src_imm     = 2'd1,  // rs1, imm
        src_pc_four = 2'd2,  // pc, 4 (link value)
        src_pc_imm  = 2'd3   // pc, imm
    } alu_src_e;

    typedef enum logic [1:0] {
        imm_i = 2'd0,
        imm_b = 2'd1,
        imm_j = 2'd2,
        imm_u = 2'd3
    } imm_op_e;

    typedef enum logic [1:0] {
        st_reset = 2'd0,
        st_run   = 2'd1,
        st_halt  = 2'd2
    } core_state_e;

endpackage

//--- source/ctrl.sv
`timescale 1ns/1ps

module ctrl
    import rvseed_pkg::*;
(
    input  logic [inst_width-1:0]     inst,      // instruction from fetch port
    output logic                      branch,    // conditional branch
    output logic                      jump,      // jal or jalr
    output logic                      jalr,      // target from rs1
    output logic                      wb_en,     // rd gets written
    output logic [reg_addr_width-1:0] wb_addr,
    output logic [reg_addr_width-1:0] rs1_addr,
    output logic [reg_addr_width-1:0] rs2_addr,
    output imm_op_e                   imm_op,
    output alu_op_e                   alu_op,
    output alu_src_e                  alu_src,
    output logic                      ebreak,
    output logic                      illegal    // outside the supported subset
);

    opcode_e                   opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [reg_addr_width-1:0] rd;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign ebreak = (inst == inst_ebreak);  // exact match only

    always_comb begin
        // safe defaults, nothing written
        branch   = 1'b0;
        jump     = 1'b0;
        jalr     = 1'b0;
        wb_en    = 1'b0;
        wb_addr  = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        imm_op   = imm_i;
        alu_op   = alu_and;
        alu_src  = src_reg;
        illegal  = 1'b0;

        case (opcode)
            op_r_type: begin
                if (funct3 == funct3_add) begin
                    wb_en    = 1'b1;
                    wb_addr  = rd;
                    rs1_addr = rs1;
                    rs2_addr = rs2;
                    alu_src  = src_reg;
                    alu_op   = (funct7 == funct7_sub) ? alu_sub : alu_add;
                end else begin
                    illegal = 1'b1;
                end
            end
            op_i_alu: begin
                if (funct3 == funct3_add) begin  // addi
                    wb_en    = 1'b1;
                    wb_addr  = rd;
                    rs1_addr = rs1;
                    imm_op   = imm_i;
                    alu_src  = src_imm;
                    alu_op   = alu_add;
                end else begin
                    illegal = 1'b1;
                end
            end
            op_branch: begin
                if (funct3 == funct3_bne) begin
                    branch   = 1'b1;
                    rs1_addr = rs1;
                    rs2_addr = rs2;
                    imm_op   = imm_b;
                    alu_src  = src_reg;
                    alu_op   = alu_sub;  // taken comes from the difference
                end else begin
                    illegal = 1'b1;
                end
            end
            op_store: begin
                illegal = 1'b1;  // no data memory
            end
            op_jal: begin
                jump    = 1'b1;
                wb_en   = 1'b1;
                wb_addr = rd;
                imm_op  = imm_j;
                alu_src = src_pc_four;  // link = pc + 4
                alu_op  = alu_add;
            end
            op_jalr: begin
                if (funct3 == funct3_jalr) begin
                    jump     = 1'b1;
                    jalr     = 1'b1;
                    wb_en    = 1'b1;
                    wb_addr  = rd;
                    rs1_addr = rs1;
                    imm_op   = imm_i;
                    alu_src  = src_pc_four;
                    alu_op   = alu_add;
                end else begin
                    illegal = 1'b1;
                end
            end
            op_lui: begin
                wb_en   = 1'b1;
                wb_addr = rd;
                imm_op  = imm_u;
                alu_src = src_imm;  // x0 + imm
                alu_op  = alu_add;
            end
            op_auipc: begin
                wb_en   = 1'b1;
                wb_addr = rd;
                imm_op  = imm_u;
                alu_src = src_pc_imm;
                alu_op  = alu_add;
            end
            op_system: begin
                illegal = (inst != inst_ebreak);  // ecall, csr ops unsupported
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- source/imm_gen.sv
`timescale 1ns/1ps

module imm_gen
    import rvseed_pkg::*;
(
    input  logic [inst_width-1:0] inst,
    input  imm_op_e               imm_op,
    output logic [xlen-1:0]       imm     // sign extended
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_op)
            imm_i: begin
                imm = {{(xlen-12){sign}}, inst[31:20]};
            end
            imm_b: begin
                // 13 bit offset, bit 0 always zero
                imm = {{(xlen-13){sign}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            imm_j: begin
                // 21 bit offset
                imm = {{(xlen-21){sign}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            imm_u: begin
                imm = {{(xlen-32){sign}}, inst[31:12], 12'b0};  // upper 20 bits << 12
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- source/regfile.sv
`timescale 1ns/1ps

module regfile
    import rvseed_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [reg_addr_width-1:0] rs1_addr,
    input  logic [reg_addr_width-1:0] rs2_addr,
    input  logic                      retire,    // instruction commits this cycle
    input  logic                      wb_en,     // instruction has a destination
    input  logic [reg_addr_width-1:0] wr_addr,
    input  logic [xlen-1:0]           wr_data,
    output logic [xlen-1:0]           rs1_data,
    output logic [xlen-1:0]           rs2_data
);

    logic [xlen-1:0] regs [1:31];  // x0 has no storage
    logic            wr_en;

    assign wr_en = retire && wb_en && (wr_addr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // reads see the value before this cycle's write
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu
    import rvseed_pkg::*;
(
    input  alu_op_e         alu_op,
    input  alu_src_e        alu_src,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] result,
    output logic            taken     // operands differ, bne condition
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] diff;

    always_comb begin
        case (alu_src)
            src_reg:     begin op_a = rs1_data; op_b = rs2_data; end
            src_imm:     begin op_a = rs1_data; op_b = imm;      end
            src_pc_four: begin op_a = pc;       op_b = xlen'(4); end
            default:     begin op_a = pc;       op_b = imm;      end
        endcase
    end

    assign diff  = op_a - op_b;
    assign taken = |diff;

    always_comb begin
        case (alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = diff;
            default: result = op_a & op_b;
        endcase
    end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import rvseed_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            branch,
    input  logic            jump,
    input  logic            jalr,
    input  logic            taken,
    input  logic            ebreak,
    input  logic            illegal,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] pc,        // also the fetch address
    output logic            retire,
    output logic            halt
);

    core_state_e     state;
    logic [xlen-1:0] jalr_sum;
    logic [xlen-1:0] next_pc;
    logic            stop;

    assign stop     = ebreak || illegal;
    assign jalr_sum = rs1_data + imm;

    always_comb begin
        if (jalr) begin
            next_pc = {jalr_sum[xlen-1:1], 1'b0};  // target bit 0 cleared
        end else if (jump || (branch && taken)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + xlen'(4);
        end
    end

    assign retire = (state == st_run) && !stop;
    assign halt   = (state == st_halt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_reset;
            pc    <= reset_pc;
        end else begin
            case (state)
                st_reset: state <= st_run;  // one idle cycle after reset
                st_run: begin
                    if (stop) begin
                        state <= st_halt;    // pc stays on the faulting inst
                    end else begin
                        pc <= next_pc;
                    end
                end
                default: state <= st_halt;  // held until reset
            endcase
        end
    end

endmodule

//--- source/rvseed_core.sv
`timescale 1ns/1ps

module rvseed_core
    import rvseed_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [inst_width-1:0]     inst,       // returned in the same cycle
    output logic [xlen-1:0]           inst_addr,
    output logic                      retire,
    output logic                      wb_en,
    output logic [reg_addr_width-1:0] wb_addr,
    output logic [xlen-1:0]           wb_data,
    output logic                      halt,
    output logic                      illegal
);

    logic                      branch;
    logic                      jump;
    logic                      jalr;
    logic                      ebreak;
    logic                      taken;
    logic [reg_addr_width-1:0] rs1_addr;
    logic [reg_addr_width-1:0] rs2_addr;
    logic [xlen-1:0]           rs1_data;
    logic [xlen-1:0]           rs2_data;
    logic [xlen-1:0]           imm;
    imm_op_e                   imm_op;
    alu_op_e                   alu_op;
    alu_src_e                  alu_src;

    ctrl u_ctrl (
        .inst     (inst),
        .branch   (branch),
        .jump     (jump),
        .jalr     (jalr),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .imm_op   (imm_op),
        .alu_op   (alu_op),
        .alu_src  (alu_src),
        .ebreak   (ebreak),
        .illegal  (illegal)
    );

    imm_gen u_imm_gen (
        .inst   (inst),
        .imm_op (imm_op),
        .imm    (imm)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .retire   (retire),
        .wb_en    (wb_en),
        .wr_addr  (wb_addr),
        .wr_data  (wb_data),   // alu result
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu u_alu (
        .alu_op   (alu_op),
        .alu_src  (alu_src),
        .pc       (inst_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .result   (wb_data),
        .taken    (taken)
    );

    fetch_unit u_fetch_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .branch   (branch),
        .jump     (jump),
        .jalr     (jalr),
        .taken    (taken),
        .ebreak   (ebreak),
        .illegal  (illegal),
        .imm      (imm),
        .rs1_data (rs1_data),
        .pc       (inst_addr),
        .retire   (retire),
        .halt     (halt)
    );

endmodule

//--- bench/tb_rvseed.sv
`timescale 1ns/1ps

module tb_rvseed
    import rvseed_pkg::*;
();

    logic                      clk;
    logic                      rst_n;
    logic [inst_width-1:0]     inst;
    logic [xlen-1:0]           inst_addr;
    logic                      retire;
    logic                      wb_en;
    logic [reg_addr_width-1:0] wb_addr;
    logic [xlen-1:0]           wb_data;
    logic                      halt;
    logic                      illegal;

    logic [31:0] imem [0:63];    // one instruction word per entry
    int          prog_len;
    logic [63:0] offset;
    logic [63:0] mregs [0:31];   // reference register file
    logic [63:0] model_pc;
    int          retire_count;
    int          branch_count;
    integer      seed;

    rvseed_core DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst      (inst),
        .inst_addr (inst_addr),
        .retire    (retire),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .halt      (halt),
        .illegal   (illegal)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_r_type};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {off[12], off[10:5], rs2, rs1, funct3_bne, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] up, input logic [4:0] rd,
                                          input opcode_e op);
        return {up, rd, op};
    endfunction

    // nop outside the loaded program
    assign offset = inst_addr - reset_pc;
    assign inst   = (offset < 64'd256) ? imem[offset[7:2]]
                                       : enc_i(12'h0, 5'd0, funct3_add, 5'd0, op_i_alu);

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got == exp) else
            fail_now($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic clear_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = enc_i(12'h0, 5'd0, funct3_add, 5'd0, op_i_alu);
        end
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // 4 cycles of reset with the model cleared
    task automatic reset_core();
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        model_pc     = reset_pc;
        retire_count = 0;
        branch_count = 0;
        repeat (4) begin
            @(negedge clk);
            check_val("retire", 64'(retire), 64'h0);
            check_val("halt", 64'(halt), 64'h0);
        end
        rst_n = 1'b1;
        check_val("retire", 64'(retire), 64'h0);  // st_reset cycle
        check_val("halt", 64'(halt), 64'h0);
        check_val("inst_addr", inst_addr, reset_pc);
    endtask

    // expected response of one committed instruction
    task automatic check_retire();
        logic [31:0] w;
        logic [4:0]  rd;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i_v;
        logic [63:0] imm_b_v;
        logic [63:0] imm_j_v;
        logic [63:0] imm_u_v;
        logic [63:0] e_data;
        logic [63:0] next_pc;
        logic        e_wb;
        check_val("inst_addr", inst_addr, model_pc);
        w       = inst;
        rd      = w[11:7];
        a       = mregs[w[19:15]];
        b       = mregs[w[24:20]];
        imm_i_v = {{52{w[31]}}, w[31:20]};
        imm_b_v = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j_v = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        imm_u_v = {{32{w[31]}}, w[31:12], 12'h000};
        e_wb    = 1'b1;
        e_data  = '0;
        next_pc = model_pc + 64'd4;
        case (opcode_e'(w[6:0]))
            op_r_type: begin
                assert (w[14:12] == funct3_add) else
                    fail_now("an R-type with unsupported funct3 retired");
                e_data = (w[31:25] == funct7_sub) ? a - b : a + b;
            end
            op_i_alu: e_data = a + imm_i_v;
            op_branch: begin
                e_wb = 1'b0;  // bne has no destination
                branch_count++;
                if (a != b) begin
                    next_pc = model_pc + imm_b_v;
                end
            end
            op_jal: begin
                e_data  = model_pc + 64'd4;
                next_pc = model_pc + imm_j_v;
            end
            op_jalr: begin
                e_data  = model_pc + 64'd4;
                next_pc = (a + imm_i_v) & ~64'd1;
            end
            op_lui:   e_data = imm_u_v;
            op_auipc: e_data = model_pc + imm_u_v;
            default:  fail_now("an instruction outside the subset retired");
        endcase
        check_val("wb_en", 64'(wb_en), 64'(e_wb));
        if (e_wb) begin
            check_val("wb_addr", 64'(wb_addr), 64'(rd));
            check_val("wb_data", wb_data, e_data);
            if (rd != 5'd0) begin
                mregs[rd] = e_data;
            end
        end
        model_pc = next_pc;
        retire_count++;
    endtask

    task automatic run_program();
        int   cycles;
        logic stopped;
        cycles  = 0;
        stopped = 1'b0;
        while (!stopped) begin
            @(negedge clk);
            if (retire) begin
                check_retire();
            end
            if (halt) begin
                stopped = 1'b1;
            end else begin
                cycles++;
                if (cycles >= 200) begin
                    fail_now("core did not halt within 200 cycles");
                end
            end
        end
        check_val("inst_addr", inst_addr, model_pc);  // pc after the last retire
    endtask

    task automatic test_reset();
        clear_program();
        emit(enc_i(12'h001, 5'd0, funct3_add, 5'd1, op_i_alu));
        emit(inst_ebreak);
        reset_core();
        run_program();
        check_val("retire_count", 64'(retire_count), 64'd1);
    endtask

    task automatic test_alu_ops();
        logic [31:0] v1;
        logic [31:0] v2;
        v1 = $random(seed);
        v2 = $random(seed);
        clear_program();
        emit(enc_u(v1[31:12], 5'd1, op_lui));
        emit(enc_i(v1[11:0], 5'd1, funct3_add, 5'd1, op_i_alu));
        emit(enc_u(v2[31:12], 5'd2, op_lui));
        emit(enc_i(v2[11:0], 5'd2, funct3_add, 5'd2, op_i_alu));
        emit(enc_r(7'h00, 5'd2, 5'd1, funct3_add, 5'd3));
        emit(enc_r(funct7_sub, 5'd2, 5'd1, funct3_add, 5'd4));
        emit(enc_r(funct7_sub, 5'd1, 5'd2, funct3_add, 5'd5));
        emit(enc_i(12'h005, 5'd1, funct3_add, 5'd0, op_i_alu));  // write to x0
        emit(enc_r(7'h00, 5'd0, 5'd0, funct3_add, 5'd6));        // must read zero
        emit(enc_r(7'h00, 5'd4, 5'd3, funct3_add, 5'd7));
        emit(inst_ebreak);
        reset_core();
        run_program();
        check_val("retire_count", 64'(retire_count), 64'd10);
    endtask

    task automatic test_branch();
        clear_program();
        emit(enc_i(12'd5, 5'd0, funct3_add, 5'd1, op_i_alu));   // loop count
        emit(enc_i(12'd1, 5'd2, funct3_add, 5'd2, op_i_alu));
        emit(enc_i(12'hfff, 5'd1, funct3_add, 5'd1, op_i_alu)); // x1 -= 1
        emit(enc_b(13'h1ff8, 5'd0, 5'd1));                      // back 8 bytes
        emit(inst_ebreak);
        reset_core();
        run_program();
        check_val("retire_count", 64'(retire_count), 64'd16);
        check_val("exit inst_addr", inst_addr, reset_pc + 64'd16);
        check_val("iterations", 64'(branch_count), 64'd5);
    endtask

    task automatic test_jumps();
        clear_program();
        emit(enc_j(21'd12, 5'd1));
        emit(enc_i(12'd1, 5'd0, funct3_add, 5'd5, op_i_alu));   // skipped
        emit(enc_i(12'd2, 5'd0, funct3_add, 5'd5, op_i_alu));   // skipped
        emit(enc_u(20'h0, 5'd2, op_auipc));
        emit(enc_i(12'd13, 5'd2, funct3_jalr, 5'd3, op_jalr));  // odd target
        emit(enc_i(12'd3, 5'd0, funct3_add, 5'd5, op_i_alu));   // skipped
        emit(enc_u(20'h1, 5'd4, op_auipc));
        emit(inst_ebreak);
        reset_core();
        run_program();
        check_val("retire_count", 64'(retire_count), 64'd4);
        check_val("halt inst_addr", inst_addr, reset_pc + 64'd28);
    endtask

    task automatic test_ebreak();
        logic [63:0] held;
        clear_program();
        emit(enc_i(12'd7, 5'd0, funct3_add, 5'd1, op_i_alu));
        emit(inst_ebreak);
        reset_core();
        run_program();
        held = inst_addr;
        repeat (10) begin
            @(negedge clk);
            check_val("halt", 64'(halt), 64'h1);
            check_val("retire", 64'(retire), 64'h0);
            check_val("inst_addr", inst_addr, held);
        end
    endtask

    task automatic run_illegal_case(input logic [31:0] word);
        clear_program();
        emit(enc_i(12'd3, 5'd0, funct3_add, 5'd1, op_i_alu));
        emit(word);
        emit(enc_i(12'd4, 5'd0, funct3_add, 5'd2, op_i_alu));
        emit(inst_ebreak);
        reset_core();
        run_program();
        check_val("illegal", 64'(illegal), 64'h1);
        check_val("retire_count", 64'(retire_count), 64'd1);
        check_val("halt inst_addr", inst_addr, reset_pc + 64'd4);
    endtask

    task automatic test_illegal();
        run_illegal_case(enc_i(12'h008, 5'd1, 3'b011, 5'd0, op_store));
        run_illegal_case(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3));  // and is not supported
        clear_program();
        emit(enc_i(12'd9, 5'd0, funct3_add, 5'd1, op_i_alu));
        emit(inst_ebreak);
        reset_core();
        run_program();
        check_val("illegal", 64'(illegal), 64'h0);
        check_val("retire_count", 64'(retire_count), 64'd1);
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        seed  = 32'hba7d;
        clear_program();
        test_reset();
        test_alu_ops();
        test_branch();
        test_jumps();
        test_ebreak();
        test_illegal();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- vlog.f
source/rvseed_pkg.sv
source/ctrl.sv
source/imm_gen.sv
source/regfile.sv
source/alu.sv
source/fetch_unit.sv
source/rvseed_core.sv
bench/tb_rvseed.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rvseed -Mdir obj_dir -f vlog.f &&
./obj_dir/Vtb_rvseed ||
{ echo "simulation did not complete successfully"; exit 1; }
